// File: Bender.yml
package:
  name: motor_ctrl

sources:
  - design/motor_spi_pkg.sv
  - design/spi_slave.sv
  - design/drive_config_regs.sv
  - design/hall_rotation_counter.sv
  - design/phase_pwm.sv
  - design/motor_ctrl_top.sv
  - target: test
    files:
      - dv/motor_ctrl_tb.sv

// File: design/drive_config_regs.sv
// configuration register: latches the spi config frame and splits it into drive fields.
module drive_config_regs (
    input  logic                                       sck,
    input  logic                                       nrst,
    input  logic                                       cfg_load,
    input  logic [motor_spi_pkg::config_width-1:0]     cfg_frame,
    output logic [7:0]                                 duty_a,
    output logic [7:0]                                 duty_b,
    output logic [7:0]                                 duty_c,
    output logic [7:0]                                 pwm_period,
    output logic [motor_spi_pkg::hall_filter_width-1:0] hall_filter,
    output logic                                       enable,
    output logic                                       reverse
);

    // live configuration word.
    motor_spi_pkg::drive_config_u cfg;

    // ****************************************
    // load from spi
    // ****************************************

    // whole frame is taken at once, fields change together.
    // visible one cycle after the cfg_load strobe.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            // drive disabled, full period, filter of 3.
            cfg.bytes <= motor_spi_pkg::default_config;
        end else if (cfg_load) begin
            cfg.bytes <= cfg_frame;
        end
    end

    // ****************************************
    // field decode
    // ****************************************

    // duties are compared against the pwm counter.
    assign duty_a = cfg.fields.duty_a;
    assign duty_b = cfg.fields.duty_b;
    assign duty_c = cfg.fields.duty_c;

    // counter top value, period is one more.
    assign pwm_period = cfg.fields.pwm_period;

    // extra stable cycles a hall code needs.
    assign hall_filter = cfg.fields.hall_filter;

    // control byte bits.
    assign enable  = cfg.fields.control[motor_spi_pkg::ctrl_enable_bit];
    assign reverse = cfg.fields.control[motor_spi_pkg::ctrl_reverse_bit];

endmodule

// File: design/hall_rotation_counter.sv
// hall input synchronizer, glitch filter and signed commutation step counter.
module hall_rotation_counter (
    input  logic                                        sck,
    input  logic                                        nrst,
    input  logic [2:0]                                  hall,
    input  logic [motor_spi_pkg::hall_filter_width-1:0] hall_filter,
    output logic [motor_spi_pkg::pos_width-1:0]         position
);

    // two flop synchronizer.
    logic [2:0] hall_meta;
    logic [2:0] hall_sync;
    // code seen on the previous cycle, and how long it has held.
    logic [2:0] hall_cand;
    logic [motor_spi_pkg::hall_filter_width:0] stable_cnt;
    // last code that passed the filter.
    logic [2:0] hall_ref;
    logic       accept;
    logic       fwd_step;
    logic       rev_step;

    // ****************************************
    // synchronizer and stability counter
    // ****************************************

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            hall_meta  <= 3'd0;
            hall_sync  <= 3'd0;
            hall_cand  <= 3'd0;
            stable_cnt <= '0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
            hall_cand <= hall_sync;
            if (hall_sync != hall_cand) begin
                // any change restarts the count.
                stable_cnt <= '0;
            end else if (stable_cnt <= {1'b0, hall_filter}) begin
                // saturates once the filter is met.
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // held for hall_filter plus 1 cycles and still the same.
    assign accept = (hall_sync == hall_cand) && (stable_cnt > {1'b0, hall_filter})
                    && (hall_cand != hall_ref);

    // ****************************************
    // step direction
    // ****************************************

    // invalid codes map to themselves in the table, so a step into or
    // out of 0 or 7 matches neither direction.
    assign fwd_step = (hall_cand == motor_spi_pkg::hall_next_fwd[hall_ref]);
    assign rev_step = (hall_ref == motor_spi_pkg::hall_next_fwd[hall_cand]);

    // two's complement count, wraps modulo 2^16.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            hall_ref <= 3'd0;
            position <= '0;
        end else if (accept) begin
            // skips and invalid codes only move the reference.
            hall_ref <= hall_cand;
            if (fwd_step) begin
                position <= position + 1'b1;
            end else if (rev_step) begin
                position <= position - 1'b1;
            end
        end
    end

endmodule

// File: design/motor_ctrl_top.sv
// motor control top: spi slave, config registers, hall counter and pwm generator.
module motor_ctrl_top (
    input  logic       sck,
    input  logic       nrst,
    input  logic       ss,
    input  logic       mosi,
    input  logic [2:0] hall,
    output logic       miso,
    output logic       pwm_a,
    output logic       pwm_b,
    output logic       pwm_c
);

    // spi to config registers.
    logic                                        cfg_load;
    logic [motor_spi_pkg::config_width-1:0]      cfg_frame;
    // config fields to the drive logic.
    logic [7:0]                                  duty_a;
    logic [7:0]                                  duty_b;
    logic [7:0]                                  duty_c;
    logic [7:0]                                  pwm_period;
    logic [motor_spi_pkg::hall_filter_width-1:0] hall_filter;
    logic                                        enable;
    logic                                        reverse;
    // hall count back to spi readback.
    logic [motor_spi_pkg::pos_width-1:0]         position;

    // ****************************************
    // command port
    // ****************************************

    spi_slave u_spi_slave (
        .sck       (sck),
        .nrst      (nrst),
        .ss        (ss),
        .mosi      (mosi),
        .position  (position),
        .miso      (miso),
        .cfg_load  (cfg_load),
        .cfg_frame (cfg_frame)
    );

    drive_config_regs u_drive_config_regs (
        .sck         (sck),
        .nrst        (nrst),
        .cfg_load    (cfg_load),
        .cfg_frame   (cfg_frame),
        .duty_a      (duty_a),
        .duty_b      (duty_b),
        .duty_c      (duty_c),
        .pwm_period  (pwm_period),
        .hall_filter (hall_filter),
        .enable      (enable),
        .reverse     (reverse)
    );

    // ****************************************
    // motor side
    // ****************************************

    hall_rotation_counter u_hall_rotation_counter (
        .sck         (sck),
        .nrst        (nrst),
        .hall        (hall),
        .hall_filter (hall_filter),
        .position    (position)
    );

    phase_pwm u_phase_pwm (
        .sck        (sck),
        .nrst       (nrst),
        .duty_a     (duty_a),
        .duty_b     (duty_b),
        .duty_c     (duty_c),
        .pwm_period (pwm_period),
        .enable     (enable),
        .reverse    (reverse),
        .pwm_a      (pwm_a),
        .pwm_b      (pwm_b),
        .pwm_c      (pwm_c)
    );

endmodule

// File: design/motor_spi_pkg.sv
// spi command codes, frame sizes, drive defaults, hall order and the config word union.
package motor_spi_pkg;

    // ****************************************
    // spi commands and frame layout
    // ****************************************

    // command byte that opens a configuration frame.
    localparam logic [7:0] config_command = 8'hBF;
    // command byte that requests the rotation count.
    localparam logic [7:0] rotation_command = 8'h4C;
    // data bytes that follow config_command.
    localparam int config_bytes = 6;
    localparam int config_width = 48;
    // miso level between transfers.
    localparam logic idle_miso = 1'b1;

    // frame states of the spi slave.
    localparam logic [1:0] frame_idle = 2'd0;
    localparam logic [1:0] frame_config = 2'd1;
    localparam logic [1:0] frame_transmit = 2'd2;

    // ****************************************
    // rotation count and hall sensors
    // ****************************************

    localparam int pos_width = 16;
    localparam int hall_filter_width = 8;
    // next code in the forward order 1, 3, 2, 6, 4, 5.
    // codes 0 and 7 are invalid and map to themselves.
    localparam logic [7:0][2:0] hall_next_fwd = {
        3'd7, 3'd4, 3'd1, 3'd5, 3'd2, 3'd6, 3'd3, 3'd0
    };

    // ****************************************
    // drive configuration
    // ****************************************

    // bit positions inside the control byte.
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_reverse_bit = 1;
    localparam logic [7:0] default_period = 8'hFF;
    localparam logic [7:0] default_filter = 8'd3;
    // filter 3, control 0, period ff, duties 0.
    localparam logic [config_width-1:0] default_config = {
        default_filter, 8'h00, default_period, 24'h000000
    };

    // frame loads it byte by byte, the drive logic reads fields.
    // byte 0 sits in the low bits, so duty_a is listed last.
    typedef union packed {
        logic [config_bytes-1:0][7:0] bytes;
        struct packed {
            logic [7:0] hall_filter;
            logic [7:0] control;
            logic [7:0] pwm_period;
            logic [7:0] duty_c;
            logic [7:0] duty_b;
            logic [7:0] duty_a;
        } fields;
    } drive_config_u;

endpackage

// File: design/phase_pwm.sv
// three phase pwm generator with wrap-aligned config update and b/c swap for reverse.
module phase_pwm (
    input  logic       sck,
    input  logic       nrst,
    input  logic [7:0] duty_a,
    input  logic [7:0] duty_b,
    input  logic [7:0] duty_c,
    input  logic [7:0] pwm_period,
    input  logic       enable,
    input  logic       reverse,
    output logic       pwm_a,
    output logic       pwm_b,
    output logic       pwm_c
);

    logic [7:0] pwm_cnt;
    logic       pwm_wrap;
    // shadow copies, only updated at the wrap.
    logic [7:0] sh_duty_a;
    logic [7:0] sh_duty_b;
    logic [7:0] sh_duty_c;
    logic [7:0] sh_period;
    logic       sh_enable;
    logic       sh_reverse;

    // ****************************************
    // period counter and shadow registers
    // ****************************************

    // >= also catches a period that shrank under the counter.
    assign pwm_wrap = (pwm_cnt >= sh_period);

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            pwm_cnt    <= 8'd0;
            sh_duty_a  <= 8'd0;
            sh_duty_b  <= 8'd0;
            sh_duty_c  <= 8'd0;
            sh_period  <= motor_spi_pkg::default_period;
            sh_enable  <= 1'b0;
            sh_reverse <= 1'b0;
        end else if (pwm_wrap) begin
            pwm_cnt    <= 8'd0;
            // new settings start on a clean period.
            sh_duty_a  <= duty_a;
            sh_duty_b  <= duty_b;
            sh_duty_c  <= duty_c;
            sh_period  <= pwm_period;
            sh_enable  <= enable;
            sh_reverse <= reverse;
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1;
        end
    end

    // ****************************************
    // output compare
    // ****************************************

    // registered so the pins never glitch.
    // reverse swaps the drive on phases b and c.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            pwm_a <= 1'b0;
            pwm_b <= 1'b0;
            pwm_c <= 1'b0;
        end else begin
            pwm_a <= sh_enable && (pwm_cnt < sh_duty_a);
            pwm_b <= sh_enable && (pwm_cnt < (sh_reverse ? sh_duty_c : sh_duty_b));
            pwm_c <= sh_enable && (pwm_cnt < (sh_reverse ? sh_duty_b : sh_duty_c));
        end
    end

endmodule

// File: design/spi_slave.sv
// spi slave: byte shifter, config and rotation frame decoder, miso transmit shifter.
module spi_slave (
    input  logic                                     sck,
    input  logic                                     nrst,
    input  logic                                     ss,
    input  logic                                     mosi,
    input  logic [motor_spi_pkg::pos_width-1:0]      position,
    output logic                                     miso,
    output logic                                     cfg_load,
    output logic [motor_spi_pkg::config_width-1:0]   cfg_frame
);

    // receive side.
    logic [6:0] rx_shift;
    logic [2:0] bit_cnt;
    logic [7:0] rx_byte;
    logic       byte_done;

    // frame tracking.
    logic [1:0] frame_state;
    logic [2:0] byte_idx;
    logic [motor_spi_pkg::config_bytes-1:0][7:0] frame_buf;

    // transmit side.
    logic [7:0] tx_shift;
    logic [7:0] tx_high;
    logic       rot_start;

    // ****************************************
    // receive shifter and bit counter
    // ****************************************

    // the byte as it stands once the current mosi bit is in.
    assign rx_byte = {rx_shift, mosi};
    // eighth bit of a byte arrives on this edge.
    assign byte_done = ~ss && (bit_cnt == 3'd7);

    // counts bits of the current byte, wraps after eight.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= 3'd0;
        end else if (ss) begin
            // deselect restarts byte alignment.
            bit_cnt <= 3'd0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // msb first, so new bits enter at the bottom.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            rx_shift <= 7'd0;
        end else if (!ss) begin
            rx_shift <= rx_byte[6:0];
        end
    end

    // ****************************************
    // frame decoder
    // ****************************************

    // rotation command seen outside any frame.
    assign rot_start = byte_done && (frame_state == motor_spi_pkg::frame_idle)
                       && (rx_byte == motor_spi_pkg::rotation_command);

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            frame_state <= motor_spi_pkg::frame_idle;
            byte_idx    <= 3'd0;
            cfg_load    <= 1'b0;
        end else begin
            // single cycle strobe.
            cfg_load <= 1'b0;
            if (ss) begin
                // deselect aborts whatever frame is open.
                frame_state <= motor_spi_pkg::frame_idle;
                byte_idx    <= 3'd0;
            end else if (byte_done) begin
                case (frame_state)
                    motor_spi_pkg::frame_idle: begin
                        // command bytes are only decoded here.
                        byte_idx <= 3'd0;
                        if (rx_byte == motor_spi_pkg::config_command) begin
                            frame_state <= motor_spi_pkg::frame_config;
                        end else if (rot_start) begin
                            frame_state <= motor_spi_pkg::frame_transmit;
                        end
                    end
                    motor_spi_pkg::frame_config: begin
                        if (byte_idx == 3'(motor_spi_pkg::config_bytes - 1)) begin
                            // last data byte lands in frame_buf on this same edge.
                            cfg_load    <= 1'b1;
                            frame_state <= motor_spi_pkg::frame_idle;
                            byte_idx    <= 3'd0;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                        end
                    end
                    motor_spi_pkg::frame_transmit: begin
                        // low byte then high byte of the snapshot.
                        if (byte_idx == 3'(motor_spi_pkg::pos_width / 8 - 1)) begin
                            frame_state <= motor_spi_pkg::frame_idle;
                            byte_idx    <= 3'd0;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                        end
                    end
                    default: begin
                        frame_state <= motor_spi_pkg::frame_idle;
                        byte_idx    <= 3'd0;
                    end
                endcase
            end
        end
    end

    // data byte k goes to byte k of the frame.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            frame_buf <= '0;
        end else if (byte_done && (frame_state == motor_spi_pkg::frame_config)) begin
            frame_buf[byte_idx] <= rx_byte;
        end
    end

    assign cfg_frame = frame_buf;

    // ****************************************
    // transmit shifter
    // ****************************************

    // both bytes are captured together so the readback is coherent.
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            tx_shift <= 8'hFF;
            tx_high  <= 8'h00;
        end else if (rot_start) begin
            tx_shift <= position[7:0];
            tx_high  <= position[15:8];
        end else if (byte_done && (frame_state == motor_spi_pkg::frame_transmit)
                     && (byte_idx == 3'd0)) begin
            // low byte is out, move on to the high byte.
            tx_shift <= tx_high;
        end else if (!ss) begin
            tx_shift <= {tx_shift[6:0], motor_spi_pkg::idle_miso};
        end
    end

    // msb of the shifter while transmitting, idle level otherwise.
    assign miso = (frame_state == motor_spi_pkg::frame_transmit) ? tx_shift[7]
                                                                  : motor_spi_pkg::idle_miso;

endmodule

// File: dv/motor_ctrl_tb.sv
// motor control testbench: data file steps, spi frames, hall sequences, pwm and readback checks.
module motor_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ****************************************
    // constants and signals
    // ****************************************

    localparam int clk_half = 20;
    // inputs change this long after the rising edge.
    localparam int drive_delay = 5;
    localparam int reset_cycles = 16;
    localparam int max_steps = 64;
    // covers the longest old period plus the config and output register delays.
    localparam int pwm_settle = 260;
    // step opcodes are ascii letters.
    localparam logic [7:0] op_config = 8'h43;
    localparam logic [7:0] op_hall = 8'h48;
    localparam logic [7:0] op_read = 8'h52;
    localparam logic [7:0] op_pwm = 8'h50;
    localparam logic [7:0] op_abort = 8'h58;

    logic       sck;
    logic       nrst;
    logic       ss;
    logic       mosi;
    logic [2:0] hall;
    logic       miso;
    logic       pwm_a;
    logic       pwm_b;
    logic       pwm_c;

    // op, six argument bytes, three 16 bit expected values.
    logic [103:0] steps [0:max_steps-1];
    int     n_steps;
    int     total_cycles;
    int     parse_filter;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    int     errors = 0;
    int     i;
    integer seed = 61;
    // drive settings as last loaded, and the expected rotation count.
    logic [47:0] cur_cfg;
    logic [7:0]  cur_period;
    logic [7:0]  cur_filter;
    logic [2:0]  model_ref;
    logic [15:0] model_pos;
    // an aborted frame waits for a full frame after the next pwm step.
    logic        resend_pending;

    motor_ctrl_top dut (
        .sck   (sck),
        .nrst  (nrst),
        .ss    (ss),
        .mosi  (mosi),
        .hall  (hall),
        .miso  (miso),
        .pwm_a (pwm_a),
        .pwm_b (pwm_b),
        .pwm_c (pwm_c)
    );

    initial begin
        sck = 1'b0;
        forever #clk_half sck = ~sck;
    end

    // cycle watchdog, limit comes from the step lengths.
    always @(posedge sck) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            end_with_failure($sformatf("run did not finish within %0d clock cycles", cycle_limit));
        end
    end

    // ****************************************
    // helpers
    // ****************************************

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            $display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            end_with_failure("value mismatch");
        end
    endtask

    // forward hall order 1, 3, 2, 6, 4, 5. invalid codes point at themselves.
    function automatic logic [2:0] next_fwd_code(input logic [2:0] code);
        case (code)
            3'd1: return 3'd3;
            3'd3: return 3'd2;
            3'd2: return 3'd6;
            3'd6: return 3'd4;
            3'd4: return 3'd5;
            3'd5: return 3'd1;
            default: return code;
        endcase
    endfunction

    // clock cycles a step takes, for the watchdog.
    function automatic int step_cycles(input logic [103:0] step, input int filter);
        int hold;
        hold = int'(step[87:80]);
        case (step[103:96])
            op_config: return 7 * 8 + 2;
            op_abort: return 3 * 8 + 2 + 7 * 8 + 2 + pwm_settle + 256;
            op_read: return 3 * 8 + 2;
            op_hall: return hold + ((hold < filter + 3) ? filter + 12 : 0);
            op_pwm: return pwm_settle + 256;
            default: return 0;
        endcase
    endfunction

    task automatic tick();
        @(posedge sck);
        #drive_delay;
    endtask

    // msb first. miso is taken before the edge that shifts it.
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            rx[b] = miso;
            tick();
        end
    endtask

    // config command then n data bytes. fewer than six is an aborted frame.
    task automatic send_frame(input logic [47:0] args, input int n);
        logic [7:0] unused;
        ss = 1'b0;
        shift_byte(motor_spi_pkg::config_command, unused);
        for (int k = 0; k < n; k++) begin
            shift_byte(args[47-8*k -: 8], unused);
        end
        ss = 1'b1;
        tick();
        tick();
    endtask

    // low byte comes first, filler mosi bytes are random payload.
    task automatic read_position(output logic [15:0] pos);
        logic [7:0] unused;
        logic [7:0] lo;
        logic [7:0] hi;
        ss = 1'b0;
        shift_byte(motor_spi_pkg::rotation_command, unused);
        shift_byte(8'($random(seed)), lo);
        shift_byte(8'($random(seed)), hi);
        ss = 1'b1;
        tick();
        tick();
        pos = {hi, lo};
        // back to idle level after the two bytes.
        compare_value("miso", 32'd1, miso);
    endtask

    // a code counts once it survives two sync flops and filter plus 1 stable cycles.
    task automatic hold_hall(input logic [2:0] code, input int hold);
        hall = code;
        repeat (hold) tick();
        if ((hold >= int'(cur_filter) + 3) && (code != model_ref)) begin
            if (code == next_fwd_code(model_ref)) begin
                model_pos = model_pos + 16'd1;
            end else if (model_ref == next_fwd_code(code)) begin
                model_pos = model_pos - 16'd1;
            end
            model_ref = code;
        end
    endtask

    // a short glitch is followed by the code after it, so a glitch that
    // slipped through would leave a count the next step does not undo.
    task automatic drive_hall(input logic [2:0] code, input logic [7:0] hold);
        hold_hall(code, int'(hold));
        if ((int'(hold) < int'(cur_filter) + 3) && (next_fwd_code(code) != code)) begin
            hold_hall(next_fwd_code(code), int'(cur_filter) + 12);
        end
    endtask

    // any window of one full period holds exactly the high cycles of a period.
    task automatic measure_pwm(output int cnt_a, output int cnt_b, output int cnt_c);
        cnt_a = 0;
        cnt_b = 0;
        cnt_c = 0;
        repeat (pwm_settle) tick();
        repeat (int'(cur_period) + 1) begin
            cnt_a += pwm_a;
            cnt_b += pwm_b;
            cnt_c += pwm_c;
            tick();
        end
    endtask

    task automatic check_pwm(input logic [15:0] exp_a, input logic [15:0] exp_b,
                             input logic [15:0] exp_c);
        int cnt_a;
        int cnt_b;
        int cnt_c;
        measure_pwm(cnt_a, cnt_b, cnt_c);
        compare_value("pwm_a high cycles", exp_a, cnt_a);
        compare_value("pwm_b high cycles", exp_b, cnt_b);
        compare_value("pwm_c high cycles", exp_c, cnt_c);
    endtask

    // ****************************************
    // step execution
    // ****************************************

    task automatic run_step(input logic [103:0] step);
        logic [7:0]  op;
        logic [47:0] args;
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        logic [15:0] exp_c;
        logic [15:0] got;
        op = step[103:96];
        args = step[95:48];
        exp_a = step[47:32];
        exp_b = step[31:16];
        exp_c = step[15:0];
        case (op)
            op_config: begin
                send_frame(args, 6);
                cur_cfg = args;
                cur_period = args[23:16];
                cur_filter = args[7:0];
            end
            op_abort: begin
                send_frame(args, 2);
                resend_pending = 1'b1;
            end
            op_hall: drive_hall(args[42:40], args[39:32]);
            op_read: begin
                read_position(got);
                compare_value("position", model_pos, got);
                compare_value("testdata position", exp_a, model_pos);
            end
            op_pwm: begin
                check_pwm(exp_a, exp_b, exp_c);
                // a full frame only lands whole if ss closed the cut frame.
                if (resend_pending) begin
                    resend_pending = 1'b0;
                    send_frame(cur_cfg, 6);
                    check_pwm(exp_a, exp_b, exp_c);
                end
            end
            default: end_with_failure("data file holds an unknown step opcode");
        endcase
    endtask

    initial begin
        nrst = 1'b0;
        ss = 1'b1;
        mosi = 1'b0;
        hall = 3'd0;
        for (i = 0; i < max_steps; i++) begin
            steps[i] = '0;
        end
        $readmemh("dv/motor_ctrl_testdata.txt", steps);
        n_steps = 0;
        total_cycles = 0;
        parse_filter = 3;
        while (n_steps < max_steps && steps[n_steps][103:96] != 8'h00) begin
            total_cycles += step_cycles(steps[n_steps], parse_filter);
            if (steps[n_steps][103:96] == op_config) begin
                parse_filter = int'(steps[n_steps][55:48]);
            end
            n_steps++;
        end
        if (n_steps == 0) begin
            end_with_failure("no test steps were read from the data file");
        end
        cycle_limit = 2 * (total_cycles + reset_cycles);
        // reset state of the drive model.
        cur_cfg = 48'h0000_00ff_0003;
        cur_period = 8'hFF;
        cur_filter = 8'd3;
        model_ref = 3'd0;
        model_pos = 16'd0;
        resend_pending = 1'b0;
        repeat (reset_cycles) @(posedge sck);
        #drive_delay;
        nrst = 1'b1;
        tick();
        compare_value("miso", 32'd1, miso);
        for (i = 0; i < n_steps; i++) begin
            run_step(steps[i]);
        end
        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            end_with_failure("one or more checks did not match");
        end
    end

endmodule

// File: dv/motor_ctrl_testdata.txt
// op(43 C, 48 H, 52 R, 50 P, 58 X) _ arg bytes 0..5 _ expected 0 _ expected 1 _ expected 2
// C/X args: duty_a duty_b duty_c period control filter. H args: code hold. P: a b c counts.
// reset state, drive disabled over a default period
50_00_00_00_00_00_00_0000_0000_0000
// enabled, period 7f, duty_c limited to period plus 1
43_40_20_90_7f_01_03_0000_0000_0000
50_00_00_00_00_00_00_0040_0020_0080
// reverse swaps b and c
43_40_20_90_7f_03_03_0000_0000_0000
50_00_00_00_00_00_00_0040_0080_0020
// forward run, first code only sets the reference
48_01_0c_00_00_00_00_0000_0000_0000
48_03_0c_00_00_00_00_0000_0000_0000
48_02_0c_00_00_00_00_0000_0000_0000
48_06_0c_00_00_00_00_0000_0000_0000
48_04_0c_00_00_00_00_0000_0000_0000
48_05_0c_00_00_00_00_0000_0000_0000
48_01_0c_00_00_00_00_0000_0000_0000
52_00_00_00_00_00_00_0006_0000_0000
// backward run of eight
48_05_0c_00_00_00_00_0000_0000_0000
48_04_0c_00_00_00_00_0000_0000_0000
48_06_0c_00_00_00_00_0000_0000_0000
48_02_0c_00_00_00_00_0000_0000_0000
48_03_0c_00_00_00_00_0000_0000_0000
48_01_0c_00_00_00_00_0000_0000_0000
48_05_0c_00_00_00_00_0000_0000_0000
48_04_0c_00_00_00_00_0000_0000_0000
52_00_00_00_00_00_00_fffe_0000_0000
// invalid codes and a skip leave the count alone
48_00_0c_00_00_00_00_0000_0000_0000
48_07_0c_00_00_00_00_0000_0000_0000
48_06_0c_00_00_00_00_0000_0000_0000
48_05_0c_00_00_00_00_0000_0000_0000
52_00_00_00_00_00_00_fffe_0000_0000
// short glitch to 1 is filtered, then a real step
48_01_04_00_00_00_00_0000_0000_0000
48_05_0c_00_00_00_00_0000_0000_0000
52_00_00_00_00_00_00_fffe_0000_0000
48_01_0c_00_00_00_00_0000_0000_0000
52_00_00_00_00_00_00_ffff_0000_0000
// frame cut after three bytes keeps the reverse config
58_10_10_10_10_00_00_0000_0000_0000
50_00_00_00_00_00_00_0040_0080_0020
52_00_00_00_00_00_00_ffff_0000_0000

// File: sources.f
design/motor_spi_pkg.sv
design/spi_slave.sv
design/drive_config_regs.sv
design/hall_rotation_counter.sv
design/phase_pwm.sv
design/motor_ctrl_top.sv
dv/motor_ctrl_tb.sv
